// ==== gb_cpu_io.f ====
+incdir+include
source/gb_cpu_io_pkg.sv
source/io_decode.sv
source/irq_ctrl.sv
source/sys_regs.sv
source/io_read_mux.sv
source/gb_cpu_io.sv
tb/gb_cpu_io_properties.sv
tb/tb_gb_cpu_io.sv

// ==== include/gb_cpu_io_params.svh ====
// cpu i/o register block constants
// register addresses, reset values and interrupt vector layout

`ifndef GB_CPU_IO_PARAMS_SVH
`define GB_CPU_IO_PARAMS_SVH

// ----------------------------------------
// register addresses
`define GB_ADDR_JOYP        16'hFF00 // joypad select / lines
`define GB_ADDR_IF          16'hFF0F // interrupt flags
`define GB_ADDR_KEY1        16'hFF4D // speed switch, colour only
`define GB_ADDR_VBK         16'hFF4F // vram bank
`define GB_ADDR_BOOT        16'hFF50 // boot rom disable
`define GB_ADDR_SVBK        16'hFF70 // wram bank
`define GB_ADDR_FF72        16'hFF72
`define GB_ADDR_FF73        16'hFF73
`define GB_ADDR_FF74        16'hFF74
`define GB_ADDR_FF75        16'hFF75 // bits 6:4 only
`define GB_ADDR_IE          16'hFFFF // interrupt enable

// ----------------------------------------
// interrupt vectors, vblank highest
`define GB_IRQ_VEC_BASE     8'h40
`define GB_IRQ_VEC_STEP     8'h08

// misc values
`define GB_WRAM_BANK_RESET  3'd1   // bank 0 maps to 1
`define GB_BOOT_OFF_CGB     8'h11  // colour boot rom exit value
`define GB_OPEN_READ        8'hFF  // unmapped read

`endif

// ==== source/gb_cpu_io.sv ====
// cpu i/o register block, top level
// decoder feeding the interrupt controller, system registers and read mux
`default_nettype none
`timescale 1ns/10ps

module gb_cpu_io (
	input  wire                        clk_sys,
	input  wire                        reset_ss,
	input  wire gb_cpu_io_pkg::cpu_addr_t cpu_addr,
	input  wire gb_cpu_io_pkg::cpu_data_t cpu_dout,  // cpu write data
	input  wire                        cpu_wr,
	input  wire                        cpu_iorq_n,
	input  wire                        cpu_m1_n,
	input  wire                        cpu_stop,
	input  wire gb_cpu_io_pkg::irq_src_t irq_src,
	input  wire [3:0]                  joy_din,
	input  wire                        is_gbc,
	input  wire                        is_gbc_game,
	output gb_cpu_io_pkg::cpu_data_t   cpu_din,   // cpu read data
	output logic                       irq_n,
	output logic [1:0]                 joy_p54,
	output logic                       speed,
	output logic                       boot_rom_enabled
);

	gb_cpu_io_pkg::io_sel_t    sel;
	gb_cpu_io_pkg::cpu_wr_t    wr;
	gb_cpu_io_pkg::irq_mask_t  if_r;
	gb_cpu_io_pkg::cpu_data_t  ie_r;
	gb_cpu_io_pkg::sys_state_t state;
	logic                      irq_ack;

	// ----------------------------------------
	io_decode i_io_decode (.clk_sys, .reset_ss, .cpu_addr, .cpu_dout, .cpu_wr,
		.is_gbc, .is_gbc_game, .boot_rom_enabled, .sel, .wr);

	irq_ctrl i_irq_ctrl (.clk_sys, .reset_ss, .sel, .wr, .irq_src, .joy_din,
		.cpu_iorq_n, .cpu_m1_n, .if_r, .ie_r, .irq_ack, .irq_n);

	sys_regs i_sys_regs (.clk_sys, .reset_ss, .sel, .wr, .cpu_stop, .is_gbc,
		.state, .boot_rom_enabled, .speed, .joy_p54);

	io_read_mux i_io_read_mux (.sel, .irq_ack, .if_r, .ie_r, .state, .joy_din,
		.cpu_din);

endmodule

`default_nettype wire

// ==== source/gb_cpu_io_pkg.sv ====
// cpu i/o register block types
// bus vectors and the structs passed between decoder, irq and sys regs
`default_nettype none

package gb_cpu_io_pkg;

	typedef logic [15:0] cpu_addr_t;  // cpu address bus
	typedef logic [7:0]  cpu_data_t;  // cpu data bus
	typedef logic [4:0]  irq_mask_t;  // bit 0 vblank .. bit 4 joypad
	typedef logic [2:0]  wram_bank_t; // svbk value, 1..7

	// one-hot register selects; iflag because "if" is reserved
	typedef struct packed {
		logic iflag, ie, joy, key1, vbk, boot, svbk;
		logic ff72, ff73, ff74, ff75;
	} io_sel_t;

	typedef struct packed {
		logic      start; // first cycle of a cpu write
		cpu_data_t data;
	} cpu_wr_t;

	// packed so bit 0 is vblank, same as irq_mask_t
	typedef struct packed {
		logic serial, timer, lcd, vblank;
	} irq_src_t;

	typedef struct packed {
		logic [1:0] p54;
		logic       cpu_speed, prepare_switch;
		wram_bank_t wram_bank;
		logic       vram_bank;
		cpu_data_t  ff72, ff73, ff74;
		logic [2:0] ff75;
	} sys_state_t;

endpackage

`default_nettype wire

// ==== source/io_decode.sv ====
// cpu i/o address decoder
// register selects with colour-mode gating, plus the write-start strobe
`default_nettype none
`timescale 1ns/10ps
`include "gb_cpu_io_params.svh"

module io_decode (
	input  wire                       clk_sys,
	input  wire                       reset_ss,
	input  wire gb_cpu_io_pkg::cpu_addr_t cpu_addr,
	input  wire gb_cpu_io_pkg::cpu_data_t cpu_dout,
	input  wire                       cpu_wr,           // write level from cpu
	input  wire                       is_gbc,
	input  wire                       is_gbc_game,
	input  wire                       boot_rom_enabled,
	output gb_cpu_io_pkg::io_sel_t    sel,
	output gb_cpu_io_pkg::cpu_wr_t    wr
);

	logic wr_d; // cpu_wr one cycle back
	logic cgb_game; // colour hw running a colour game

	// ----------------------------------------
	// write start detect
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			wr_d <= 1'b0;
		end else begin
			wr_d <= cpu_wr;
		end
	end

	assign wr.start = cpu_wr & ~wr_d; // low->high only
	assign wr.data  = cpu_dout;

	// ----------------------------------------
	// address compare
	assign cgb_game = is_gbc & is_gbc_game;

	always_comb begin
		sel       = '0;
		sel.iflag = (cpu_addr == `GB_ADDR_IF);
		sel.ie    = (cpu_addr == `GB_ADDR_IE);
		sel.joy   = (cpu_addr == `GB_ADDR_JOYP);
		sel.boot  = (cpu_addr == `GB_ADDR_BOOT);
		// colour game only
		sel.key1  = cgb_game & (cpu_addr == `GB_ADDR_KEY1);
		sel.ff74  = cgb_game & (cpu_addr == `GB_ADDR_FF74);
		// boot rom may bank wram before the game mode is known
		sel.svbk  = is_gbc & (is_gbc_game | boot_rom_enabled) &
			(cpu_addr == `GB_ADDR_SVBK);
		// any colour hw
		sel.vbk   = is_gbc & (cpu_addr == `GB_ADDR_VBK);
		sel.ff72  = is_gbc & (cpu_addr == `GB_ADDR_FF72);
		sel.ff73  = is_gbc & (cpu_addr == `GB_ADDR_FF73);
		sel.ff75  = is_gbc & (cpu_addr == `GB_ADDR_FF75);
	end

endmodule

`default_nettype wire

// ==== source/io_read_mux.sv ====
// cpu read data multiplexer
// interrupt vector during acknowledge, otherwise the selected register
`default_nettype none
`timescale 1ns/10ps
`include "gb_cpu_io_params.svh"

module io_read_mux (
	input  wire gb_cpu_io_pkg::io_sel_t    sel,
	input  wire                          irq_ack,
	input  wire gb_cpu_io_pkg::irq_mask_t  if_r,
	input  wire gb_cpu_io_pkg::cpu_data_t  ie_r,
	input  wire gb_cpu_io_pkg::sys_state_t state,
	input  wire [3:0]                    joy_din,
	output gb_cpu_io_pkg::cpu_data_t     cpu_din
);

	gb_cpu_io_pkg::irq_mask_t pend;
	gb_cpu_io_pkg::cpu_data_t irq_vec;
	logic [2:0] vec_idx; // index of the serviced source

	// ----------------------------------------
	// vector: base + step * lowest pending bit
	assign pend = if_r & ie_r[4:0];

	always_comb begin
		vec_idx = 3'd0;
		for (int i = 4; i >= 0; i--) // last hit is highest priority
			if (pend[i]) vec_idx = 3'(i);
		irq_vec = (|pend) ? `GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * vec_idx : 8'h00;
	end

	// ----------------------------------------
	// read priority
	always_comb begin
		if (irq_ack)       cpu_din = irq_vec;
		else if (sel.iflag) cpu_din = {3'b111, if_r};
		else if (sel.svbk) cpu_din = {5'h1f, state.wram_bank};
		else if (sel.vbk)  cpu_din = {7'h7f, state.vram_bank};
		else if (sel.key1) cpu_din = {state.cpu_speed, 6'h3f, state.prepare_switch};
		else if (sel.joy)  cpu_din = {2'b11, state.p54, joy_din};
		else if (sel.ie)   cpu_din = ie_r;
		else if (sel.ff72) cpu_din = state.ff72;
		else if (sel.ff73) cpu_din = state.ff73;
		else if (sel.ff74) cpu_din = state.ff74;
		else if (sel.ff75) cpu_din = {1'b1, state.ff75, 4'hf};
		else               cpu_din = `GB_OPEN_READ; // unmapped, FF50 too
	end

endmodule

`default_nettype wire

// ==== source/irq_ctrl.sv ====
// interrupt controller
// IF/IE registers, event edge capture, joypad falling edges and
// clear of the highest priority flag at the end of an acknowledge
`default_nettype none
`timescale 1ns/10ps

module irq_ctrl (
	input  wire                        clk_sys,
	input  wire                        reset_ss,
	input  wire gb_cpu_io_pkg::io_sel_t  sel,
	input  wire gb_cpu_io_pkg::cpu_wr_t  wr,
	input  wire gb_cpu_io_pkg::irq_src_t irq_src,
	input  wire [3:0]                  joy_din,  // P10..P13, active low
	input  wire                        cpu_iorq_n,
	input  wire                        cpu_m1_n,
	output gb_cpu_io_pkg::irq_mask_t   if_r,
	output gb_cpu_io_pkg::cpu_data_t   ie_r,
	output logic                       irq_ack,
	output logic                       irq_n
);

	gb_cpu_io_pkg::irq_src_t  src_d;     // event levels last cycle
	gb_cpu_io_pkg::irq_mask_t src_rise;  // new event and joypad edges
	gb_cpu_io_pkg::irq_mask_t pend;      // active and enabled
	gb_cpu_io_pkg::irq_mask_t ack_clr;   // lowest set bit of pend
	logic [3:0] joy_d1, joy_d2;          // two sample stages
	logic       joy_fall;
	logic       ack_d;

	// ----------------------------------------
	// edge detect
	assign src_rise = {joy_fall, irq_src & ~src_d}; // joypad on top
	assign joy_fall = |(~joy_d1 & joy_d2);       // any line went low

	assign pend    = if_r & ie_r[4:0];
	assign ack_clr = pend & (~pend + 5'd1); // vblank wins
	assign irq_ack = ~cpu_iorq_n & ~cpu_m1_n;
	assign irq_n   = ~|pend;

	// ----------------------------------------
	// flag / enable registers
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r   <= '0;
			ie_r   <= '0;
			src_d  <= '0;
			joy_d1 <= '0;
			joy_d2 <= '0;
			ack_d  <= 1'b0;
		end else begin
			src_d  <= irq_src;
			joy_d1 <= joy_din;
			joy_d2 <= joy_d1;
			ack_d  <= irq_ack;

			// events set flags
			if_r <= if_r | src_rise;

			// ack just ended, drop the serviced flag
			if (ack_d && !irq_ack)
				if_r <= (if_r | src_rise) & ~ack_clr;

			// cpu writes come last so they win
			if (wr.start && sel.iflag)
				if_r <= wr.data[4:0];
			if (wr.start && sel.ie)
				ie_r <= wr.data; // all 8 bits kept
		end
	end

endmodule

`default_nettype wire

// ==== source/sys_regs.sv ====
// system registers
// joypad select, KEY1 speed switch, vram/wram banks, boot rom latch
// and the spare colour-mode registers FF72..FF75
`default_nettype none
`timescale 1ns/10ps
`include "gb_cpu_io_params.svh"

module sys_regs (
	input  wire                       clk_sys,
	input  wire                       reset_ss,
	input  wire gb_cpu_io_pkg::io_sel_t sel,
	input  wire gb_cpu_io_pkg::cpu_wr_t wr,
	input  wire                       cpu_stop,  // cpu executing STOP
	input  wire                       is_gbc,
	output gb_cpu_io_pkg::sys_state_t state,
	output logic                      boot_rom_enabled,
	output logic                      speed,
	output logic [1:0]                joy_p54
);

	logic boot_off; // write that disables the boot rom
	logic do_switch; // speed toggle this cycle

	assign boot_off = wr.start & sel.boot &
		((is_gbc & (wr.data == `GB_BOOT_OFF_CGB)) | (~is_gbc & wr.data[0]));
	assign do_switch = is_gbc & state.prepare_switch & cpu_stop;

	// ----------------------------------------
	// register file
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			state.p54            <= '0;
			state.cpu_speed      <= 1'b0;  // normal speed
			state.prepare_switch <= 1'b0;
			state.wram_bank      <= `GB_WRAM_BANK_RESET;
			state.vram_bank      <= 1'b0;
			state.ff72           <= '0;
			state.ff73           <= '0;
			state.ff74           <= '0;
			state.ff75           <= '0;
			boot_rom_enabled     <= 1'b1;
		end else begin
			if (wr.start) begin
				if (sel.joy)  state.p54       <= wr.data[5:4];
				if (sel.key1) state.prepare_switch <= wr.data[0];
				if (sel.vbk)  state.vram_bank <= wr.data[0];
				if (sel.ff72) state.ff72      <= wr.data;
				if (sel.ff73) state.ff73      <= wr.data;
				if (sel.ff74) state.ff74      <= wr.data;
				if (sel.ff75) state.ff75      <= wr.data[6:4]; // only 6:4 exist
				if (sel.svbk) begin
					if (wr.data[2:0] == 3'd0)  // bank 0 not selectable
						state.wram_bank <= 3'd1;
					else
						state.wram_bank <= wr.data[2:0];
				end
			end

			// speed switch on STOP, beats a KEY1 write
			if (do_switch) begin
				state.cpu_speed      <= ~state.cpu_speed;
				state.prepare_switch <= 1'b0;
			end

			// one way until reset
			if (boot_off)
				boot_rom_enabled <= 1'b0;
		end
	end

	assign speed   = state.cpu_speed;
	assign joy_p54 = state.p54;

endmodule

`default_nettype wire

// ==== tb/gb_cpu_io_properties.sv ====
// cpu i/o register block properties
// irq line against IF/IE, wram bank range, speed toggle only on STOP
`default_nettype none
`timescale 1ns/10ps

module gb_cpu_io_properties (
	input wire                             clk_sys,
	input wire                             reset_ss,
	input wire                             cpu_stop,
	input wire gb_cpu_io_pkg::irq_mask_t   if_r,
	input wire gb_cpu_io_pkg::cpu_data_t   ie_r,
	input wire gb_cpu_io_pkg::sys_state_t  state,
	input wire                             irq_n,
	input wire                             speed
);

	int fail_count = 0; // assertion failures so far

	// irq line low exactly while a flag is active and enabled
	irq_n_matches: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_n == ~|(if_r & ie_r[4:0]))
		else begin
			fail_count++;
			$error("irq_n does not follow IF and IE");
		end

	wram_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset_ss)
		state.wram_bank != 3'd0)
		else begin
			fail_count++;
			$error("wram bank reads 0");
		end

	// a new speed value means STOP was high the cycle before
	speed_on_stop: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(speed != $past(speed)) |-> $past(cpu_stop))
		else begin
			fail_count++;
			$error("speed changed without cpu_stop");
		end

endmodule

bind gb_cpu_io gb_cpu_io_properties i_gb_cpu_io_properties (.clk_sys, .reset_ss,
	.cpu_stop, .if_r, .ie_r, .state, .irq_n, .speed);

`default_nettype wire

// ==== tb/tb_gb_cpu_io.sv ====
// testbench for the cpu i/o register block
// shadow register model, lfsr data, read-back of every register
`default_nettype none
`timescale 1ns/10ps
`include "gb_cpu_io_params.svh"

module tb_gb_cpu_io;

	localparam int TIMEOUT_CYCLES = 3000; // tests need a few hundred cycles

	logic                       clk_sys = 1'b0;
	logic                       reset_ss;
	gb_cpu_io_pkg::cpu_addr_t   cpu_addr;
	gb_cpu_io_pkg::cpu_data_t   cpu_dout;
	gb_cpu_io_pkg::cpu_data_t   cpu_din;
	logic                       cpu_wr, cpu_iorq_n, cpu_m1_n, cpu_stop;
	gb_cpu_io_pkg::irq_src_t    irq_src;
	logic [3:0]                 joy_din;
	logic                       is_gbc, is_gbc_game;
	logic                       irq_n, speed, boot_rom_enabled;
	logic [1:0]                 joy_p54;

	// ----------------------------------------
	// shadow registers
	logic [4:0]  m_if;
	logic [7:0]  m_ie, m_ff72, m_ff73, m_ff74;
	logic [2:0]  m_ff75, m_svbk;
	logic [1:0]  m_p54;
	logic        m_vbk, m_speed, m_prep, m_boot;
	logic [31:0] lfsr = 32'h69fec1f1;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          checks0 = 0;
	int          errors0 = 0;
	// first 8 writable in colour mode, 2..8 dead in monochrome
	logic [15:0] rd_addrs [13] = '{`GB_ADDR_IE, `GB_ADDR_IF, `GB_ADDR_FF72,
		`GB_ADDR_FF73, `GB_ADDR_FF74, `GB_ADDR_FF75, `GB_ADDR_VBK, `GB_ADDR_SVBK,
		`GB_ADDR_KEY1, `GB_ADDR_JOYP, `GB_ADDR_BOOT, 16'hFF01, 16'h0000};

	gb_cpu_io i_gb_cpu_io (.*);

	always #2 clk_sys = ~clk_sys; // 4 ns

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output logic [7:0] v);
		v = '0;
		repeat (8) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[6:0], lfsr[0]}; // one bit per step
		end
	endtask

	// expected cpu_din from the shadow registers
	function automatic logic [7:0] expect_read(input logic [15:0] a, input logic ack);
		logic [4:0] pend;
		logic       cgb_game;
		pend     = m_if & m_ie[4:0];
		cgb_game = is_gbc & is_gbc_game;
		if (ack) begin
			for (int i = 0; i < 5; i++) // bit 0 first
				if (pend[i]) return `GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * 8'(i);
			return 8'h00;
		end
		case (a)
			`GB_ADDR_IF:   return {3'b111, m_if};
			`GB_ADDR_IE:   return m_ie;
			`GB_ADDR_JOYP: return {2'b11, m_p54, joy_din};
			`GB_ADDR_KEY1: return cgb_game ? {m_speed, 6'h3f, m_prep} : 8'hff;
			`GB_ADDR_VBK:  return is_gbc ? {7'h7f, m_vbk} : 8'hff;
			`GB_ADDR_SVBK: return (is_gbc & (is_gbc_game | m_boot)) ? {5'h1f, m_svbk} : 8'hff;
			`GB_ADDR_FF72: return is_gbc ? m_ff72 : 8'hff;
			`GB_ADDR_FF73: return is_gbc ? m_ff73 : 8'hff;
			`GB_ADDR_FF74: return cgb_game ? m_ff74 : 8'hff;
			`GB_ADDR_FF75: return is_gbc ? {1'b1, m_ff75, 4'hf} : 8'hff;
			default:       return `GB_OPEN_READ;
		endcase
	endfunction

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		case (a)
			`GB_ADDR_IF:   m_if = d[4:0];
			`GB_ADDR_IE:   m_ie = d;
			`GB_ADDR_JOYP: m_p54 = d[5:4];
			`GB_ADDR_KEY1: if (is_gbc & is_gbc_game) m_prep = d[0];
			`GB_ADDR_VBK:  if (is_gbc) m_vbk = d[0];
			`GB_ADDR_SVBK: if (is_gbc & (is_gbc_game | m_boot))
				m_svbk = (d[2:0] == 3'd0) ? 3'd1 : d[2:0]; // bank 0 becomes 1
			`GB_ADDR_FF72: if (is_gbc) m_ff72 = d;
			`GB_ADDR_FF73: if (is_gbc) m_ff73 = d;
			`GB_ADDR_FF74: if (is_gbc & is_gbc_game) m_ff74 = d;
			`GB_ADDR_FF75: if (is_gbc) m_ff75 = d[6:4];
			`GB_ADDR_BOOT: if (is_gbc ? (d == `GB_BOOT_OFF_CGB) : d[0]) m_boot = 1'b0;
			default: ;
		endcase
	endtask

	task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: expected %02h, actual %02h", name, exp, act);
		end
	endtask

	// cpu_wr high one cycle, then low one cycle
	task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_dout = d;
		cpu_wr   = 1'b1;
		@(negedge clk_sys);
		cpu_wr = 1'b0;
		model_write(a, d);
	endtask

	task automatic read_check(input string name, input logic [15:0] a);
		@(negedge clk_sys);
		cpu_addr = a;
		#1 check(name, expect_read(a, !cpu_iorq_n && !cpu_m1_n), cpu_din);
	endtask

	task automatic stop_pulse();
		@(negedge clk_sys);
		cpu_stop = 1'b1;
		@(negedge clk_sys);
		cpu_stop = 1'b0;
		if (m_prep && is_gbc) begin // switch armed by KEY1
			m_speed = ~m_speed;
			m_prep  = 1'b0;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s done: %0d checks, %0d errors", name, checks - checks0,
			errors - errors0);
		checks0 = checks;
		errors0 = errors;
	endtask

	initial begin
		logic [7:0] d;
		int         k;
		reset_ss    = 1'b1;
		cpu_addr    = '0;
		cpu_dout    = '0;
		cpu_wr      = 1'b0;
		cpu_iorq_n  = 1'b1;
		cpu_m1_n    = 1'b1;
		cpu_stop    = 1'b0;
		irq_src     = '0;
		joy_din     = 4'hf; // no keys pressed
		is_gbc      = 1'b1;
		is_gbc_game = 1'b1;
		{m_if, m_ie, m_p54, m_vbk, m_speed, m_prep} = '0;
		{m_ff72, m_ff73, m_ff74, m_ff75} = '0;
		m_svbk = `GB_WRAM_BANK_RESET;
		m_boot = 1'b1;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_ss = 1'b0;

		// ----------------------------------------
		// reset values
		for (k = 0; k < 13; k++)
			read_check("reset read", rd_addrs[k]);
		check("reset irq_n", 1'b1, irq_n);
		check("reset speed", 1'b0, speed);
		check("reset boot", 1'b1, boot_rom_enabled);
		end_test("reset");

		// colour game readback, then monochrome
		repeat (4)
			for (k = 0; k < 8; k++) begin
				rand_byte(d);
				write_reg(rd_addrs[k], d);
				read_check("readback", rd_addrs[k]);
			end
		write_reg(`GB_ADDR_SVBK, 8'h00);
		read_check("svbk zero", `GB_ADDR_SVBK);
		@(negedge clk_sys);
		is_gbc = 1'b0;
		for (k = 2; k < 9; k++) begin
			rand_byte(d);
			write_reg(rd_addrs[k], d);
			read_check("mono read", rd_addrs[k]);
		end
		@(negedge clk_sys);
		is_gbc = 1'b1;
		for (k = 2; k < 9; k++)
			read_check("mono kept", rd_addrs[k]); // colour values untouched
		write_reg(`GB_ADDR_IF, 8'h00);
		write_reg(`GB_ADDR_IE, 8'h00);
		end_test("readback");

		// ----------------------------------------
		// event edges, then acknowledge in priority order
		for (k = 0; k < 4; k++) begin
			@(negedge clk_sys);
			irq_src = gb_cpu_io_pkg::irq_src_t'(4'b0001 << k);
			@(negedge clk_sys);
			irq_src  = '0;
			m_if[k] = 1'b1;
			read_check("event flag", `GB_ADDR_IF);
		end
		write_reg(`GB_ADDR_IE, 8'h1f);
		for (k = 0; k < 4; k++) begin
			check("irq_n low", 1'b0, irq_n);
			@(negedge clk_sys);
			cpu_iorq_n = 1'b0;
			cpu_m1_n   = 1'b0;
			read_check("irq vector", `GB_ADDR_IF);
			@(negedge clk_sys);
			cpu_iorq_n = 1'b1;
			cpu_m1_n   = 1'b1;
			m_if[k]    = 1'b0; // lowest pending bit goes
			read_check("irq clear", `GB_ADDR_IF);
		end
		check("irq_n high", 1'b1, irq_n);
		end_test("interrupts");

		// joypad select and falling edge flag
		rand_byte(d);
		write_reg(`GB_ADDR_JOYP, d);
		read_check("joypad read", `GB_ADDR_JOYP);
		check("joy_p54", m_p54, joy_p54);
		@(negedge clk_sys);
		joy_din = 4'b1011;
		repeat (4) @(posedge clk_sys);
		m_if[4] = 1'b1;
		read_check("joypad flag", `GB_ADDR_IF);
		read_check("joypad read", `GB_ADDR_JOYP);
		@(negedge clk_sys);
		joy_din = 4'hf;
		write_reg(`GB_ADDR_IF, 8'h00);
		end_test("joypad");

		// ----------------------------------------
		// speed switch and boot rom latch
		write_reg(`GB_ADDR_KEY1, 8'h01);
		read_check("key1 armed", `GB_ADDR_KEY1);
		stop_pulse();
		read_check("key1 switched", `GB_ADDR_KEY1);
		check("speed switched", m_speed, speed);
		stop_pulse(); // not armed
		check("speed held", m_speed, speed);
		write_reg(`GB_ADDR_BOOT, 8'h10);
		check("boot kept", m_boot, boot_rom_enabled);
		write_reg(`GB_ADDR_BOOT, 8'h11);
		check("boot off", m_boot, boot_rom_enabled);
		write_reg(`GB_ADDR_BOOT, 8'h00);
		check("boot stays off", m_boot, boot_rom_enabled);
		end_test("speed_boot");

		errors += i_gb_cpu_io.i_gb_cpu_io_properties.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
